// File: Bender.yml
package:
  name: data_mem

sources:
  - hdl/mem_op_pkg.sv
  - hdl/bus_pkg.sv
  - hdl/store_data_translator.sv
  - hdl/load_data_translator.sv
  - hdl/data_mem.sv
  - hdl/data_ram.sv
  - hdl/io_regs.sv
  - hdl/data_bus_decoder.sv
  - hdl/data_mem_top.sv
  - target: test
    files:
      - test/data_mem_tb.sv

// File: all.f
hdl/mem_op_pkg.sv
hdl/bus_pkg.sv
hdl/store_data_translator.sv
hdl/load_data_translator.sv
hdl/data_mem.sv
hdl/data_ram.sv
hdl/io_regs.sv
hdl/data_bus_decoder.sv
hdl/data_mem_top.sv
test/data_mem_tb.sv

// File: hdl/bus_pkg.sv
// Memory bus request and response structs plus exception cause codes
package bus_pkg;

    // Exception cause as seen by the processor
    typedef logic [31:0] ecause_t;

    // No exception
    localparam ecause_t ECAUSE_NONE = 32'd0;
    // Data bus error, unmapped target word
    localparam ecause_t ECAUSE_DBE  = 32'd7;

    // Request from the processor interface towards a target
    typedef struct packed {
        mem_op_pkg::addr_t   address;
        mem_op_pkg::byteen_t byteen;
        logic                we;
        logic                en;
        // Store data already on its byte lanes
        mem_op_pkg::data_t   writedata;
    } bus_req_t;

    // Response from a target
    typedef struct packed {
        // Valid in the cycle after acceptance
        mem_op_pkg::data_t readdata;
        // Target not ready, request must be held
        logic              wait_req;
        // Cause of the accepted access, one cycle after acceptance
        ecause_t           ecause;
    } bus_rsp_t;

endpackage

// File: hdl/data_bus_decoder.sv
// Data bus decoder, routes requests by address bit 31 and merges target responses
module data_bus_decoder
(
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t req,
    input  bus_pkg::bus_rsp_t ram_rsp,
    input  bus_pkg::bus_rsp_t io_rsp,
    output bus_pkg::bus_req_t ram_req,
    output bus_pkg::bus_req_t io_req,
    output bus_pkg::bus_rsp_t rsp
);

    logic sel_io;
    logic cur_wait;
    logic accept;
    // Target of the last accepted access
    logic rsp_sel_io;

    // Bit 31 set is the I/O region
    assign sel_io = req.address[31];

    // Both targets see the request, only one gets en
    always_comb
    begin
        ram_req    = req;
        ram_req.en = req.en & ~sel_io;
        io_req     = req;
        io_req.en  = req.en & sel_io;
    end

    // Wait from the target being addressed now
    assign cur_wait = sel_io ? io_rsp.wait_req : ram_rsp.wait_req;
    assign accept   = req.en & ~cur_wait;

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_sel_io <= 1'b0;
        else if (accept)
            rsp_sel_io <= sel_io;
    end

    // Result data and cause follow the accepted target,
    // so a new access to the other target can already be waiting
    always_comb
    begin
        rsp.readdata = rsp_sel_io ? io_rsp.readdata : ram_rsp.readdata;
        rsp.ecause   = rsp_sel_io ? io_rsp.ecause : ram_rsp.ecause;
        rsp.wait_req = cur_wait;
    end

endmodule

// File: hdl/data_mem.sv
// Data memory interface, builds bus requests and returns load result, stall and cause
module data_mem
(
    input  logic                clk,
    input  logic                reset,
    input  logic                en,
    input  mem_op_pkg::mem_op_t op,
    input  mem_op_pkg::addr_t   d_address,
    input  mem_op_pkg::data_t   d_writedata,
    input  bus_pkg::bus_rsp_t   bus_rsp,
    output mem_op_pkg::data_t   d_loadresult,
    output logic                stalled,
    output bus_pkg::ecause_t    ecause,
    output bus_pkg::bus_req_t   bus_req
);

    mem_op_pkg::byteen_t lane_byteen;
    mem_op_pkg::data_t   lane_data;
    logic                accept;

    // Access fields captured at acceptance, used in the result cycle
    logic [1:0]          offset_q;
    mem_op_pkg::size_t   size_q;
    logic                sign_q;

    store_data_translator i_store_data_translator
    (
        .write_data  (d_writedata),
        .byte_offset (d_address[1:0]),
        .store_size  (op[1:0]),
        .byteen      (lane_byteen),
        .lane_data   (lane_data)
    );

    // Request goes out straight from the processor side
    always_comb
    begin
        bus_req.address   = d_address;
        bus_req.byteen    = lane_byteen;
        bus_req.we        = op[mem_op_pkg::OP_STORE_BIT];
        bus_req.en        = en;
        bus_req.writedata = lane_data;
    end

    // Accepted when no target holds the bus
    assign accept = en & ~bus_rsp.wait_req;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            offset_q <= 2'b00;
            size_q   <= mem_op_pkg::SIZE_WORD;
            sign_q   <= 1'b0;
        end
        else if (accept)
        begin
            offset_q <= d_address[1:0];
            size_q   <= op[1:0];
            sign_q   <= op[mem_op_pkg::OP_SIGN_BIT];
        end
    end

    load_data_translator i_load_data_translator
    (
        .read_data   (bus_rsp.readdata),
        .byte_offset (offset_q),
        .load_size   (size_q),
        .sign_ext    (sign_q),
        .load_result (d_loadresult)
    );

    // Bus wait stalls the processor
    assign stalled = bus_rsp.wait_req;
    assign ecause  = bus_rsp.ecause;

endmodule

// File: hdl/data_mem_top.sv
// Data memory top level, joins the processor interface, bus decoder, RAM and I/O block
module data_mem_top
#(
    parameter int DM_ADDRESSWIDTH = 10,
    parameter int IO_WAIT         = 2
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                en,
    input  mem_op_pkg::mem_op_t op,
    input  mem_op_pkg::addr_t   d_address,
    input  mem_op_pkg::data_t   d_writedata,
    input  mem_op_pkg::addr_t   boot_daddr,
    input  mem_op_pkg::data_t   boot_ddata,
    input  logic                boot_dwe,
    output mem_op_pkg::data_t   d_loadresult,
    output logic                stalled,
    output bus_pkg::ecause_t    ecause
);

    // Processor side bus
    bus_pkg::bus_req_t cpu_req;
    bus_pkg::bus_rsp_t cpu_rsp;
    // Target buses
    bus_pkg::bus_req_t ram_req;
    bus_pkg::bus_rsp_t ram_rsp;
    bus_pkg::bus_req_t io_req;
    bus_pkg::bus_rsp_t io_rsp;

    data_mem i_data_mem
    (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .op           (op),
        .d_address    (d_address),
        .d_writedata  (d_writedata),
        .bus_rsp      (cpu_rsp),
        .d_loadresult (d_loadresult),
        .stalled      (stalled),
        .ecause       (ecause),
        .bus_req      (cpu_req)
    );

    data_bus_decoder i_data_bus_decoder
    (
        .clk     (clk),
        .reset   (reset),
        .req     (cpu_req),
        .ram_rsp (ram_rsp),
        .io_rsp  (io_rsp),
        .ram_req (ram_req),
        .io_req  (io_req),
        .rsp     (cpu_rsp)
    );

    data_ram #(
        .DM_ADDRESSWIDTH (DM_ADDRESSWIDTH)
    ) i_data_ram (
        .clk        (clk),
        .req        (ram_req),
        .boot_daddr (boot_daddr),
        .boot_ddata (boot_ddata),
        .boot_dwe   (boot_dwe),
        .rsp        (ram_rsp)
    );

    io_regs #(
        .IO_WAIT (IO_WAIT)
    ) i_io_regs (
        .clk   (clk),
        .reset (reset),
        .req   (io_req),
        .rsp   (io_rsp)
    );

endmodule

// File: hdl/data_ram.sv
// On-chip data RAM, byte-enabled words with registered read and a boot write port
module data_ram
#(
    parameter int DM_ADDRESSWIDTH = 10
)
(
    input  logic              clk,
    input  bus_pkg::bus_req_t req,
    input  mem_op_pkg::addr_t boot_daddr,
    input  mem_op_pkg::data_t boot_ddata,
    input  logic              boot_dwe,
    output bus_pkg::bus_rsp_t rsp
);

    localparam int DEPTH = 2 ** DM_ADDRESSWIDTH;

    // Word index inside the RAM
    typedef logic [DM_ADDRESSWIDTH-1:0] word_idx_t;

    mem_op_pkg::data_t mem [DEPTH];
    mem_op_pkg::data_t read_q;
    word_idx_t         req_idx;
    word_idx_t         boot_idx;

    // Byte address bits 1:0 are the lane offset
    assign req_idx  = req.address[DM_ADDRESSWIDTH+1:2];
    assign boot_idx = boot_daddr[DM_ADDRESSWIDTH+1:2];

    // Boot write comes last so it wins over a store to the same word
    always_ff @(posedge clk)
    begin
        if (req.en && req.we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (req.byteen[i])
                begin
                    mem[req_idx][8*i +: 8] <= req.writedata[8*i +: 8];
                end
            end
        end
        if (boot_dwe)
        begin
            mem[boot_idx] <= boot_ddata;
        end
    end

    // Read at the accepting edge, old data on a same-cycle store
    always_ff @(posedge clk)
    begin
        if (req.en)
        begin
            read_q <= mem[req_idx];
        end
    end

    // Never stalls, never faults
    always_comb
    begin
        rsp.readdata = read_q;
        rsp.wait_req = 1'b0;
        rsp.ecause   = bus_pkg::ECAUSE_NONE;
    end

endmodule

// File: hdl/io_regs.sv
// I/O register block, four word registers behind wait states, bus error when unmapped
module io_regs
#(
    parameter int IO_WAIT = 2
)
(
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp
);

    localparam int CNT_W = $clog2(IO_WAIT + 1);

    typedef logic [CNT_W-1:0] wait_cnt_t;

    mem_op_pkg::data_t regs [4];
    mem_op_pkg::data_t read_q;
    bus_pkg::ecause_t  ecause_q;
    wait_cnt_t         wait_cnt;
    logic              wait_req;
    logic              accept;
    logic              mapped;
    logic [1:0]        word_idx;

    // Word indices 0 to 3 only, bit 31 is the region select
    assign mapped   = (req.address[30:4] == '0);
    assign word_idx = req.address[3:2];

    // Wait until IO_WAIT cycles of this access have gone by
    assign wait_req = req.en && (wait_cnt != wait_cnt_t'(IO_WAIT));
    assign accept   = req.en && !wait_req;

    always_ff @(posedge clk)
    begin
        if (reset)
            wait_cnt <= '0;
        else if (!req.en || accept)
            wait_cnt <= '0;
        else
            wait_cnt <= wait_cnt + 1'b1;
    end

    // Registers and cause, stores to unmapped words are dropped
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
            ecause_q <= bus_pkg::ECAUSE_NONE;
        end
        else
        begin
            // Cause only lives for the cycle after acceptance
            ecause_q <= bus_pkg::ECAUSE_NONE;
            if (accept)
            begin
                if (!mapped)
                    ecause_q <= bus_pkg::ECAUSE_DBE;
                else if (req.we)
                begin
                    for (int i = 0; i < 4; i++)
                    begin
                        if (req.byteen[i])
                            regs[word_idx][8*i +: 8] <= req.writedata[8*i +: 8];
                    end
                end
            end
        end
    end

    // Read data captured at acceptance, zero for unmapped words
    always_ff @(posedge clk)
    begin
        if (accept)
            read_q <= mapped ? regs[word_idx] : '0;
    end

    always_comb
    begin
        rsp.readdata = read_q;
        rsp.wait_req = wait_req;
        rsp.ecause   = ecause_q;
    end

endmodule

// File: hdl/load_data_translator.sv
// Load data translator, picks a byte or halfword from read data and extends it
module load_data_translator
(
    input  mem_op_pkg::data_t read_data,
    input  logic [1:0]        byte_offset,
    input  mem_op_pkg::size_t load_size,
    input  logic              sign_ext,
    output mem_op_pkg::data_t load_result
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Byte select mirrors the store lanes
    always_comb
    begin
        case (byte_offset)
            2'd0:    sel_byte = read_data[31:24];
            2'd1:    sel_byte = read_data[23:16];
            2'd2:    sel_byte = read_data[15:8];
            default: sel_byte = read_data[7:0];
        endcase
    end

    // Upper half at even halfword offset
    assign sel_half = byte_offset[1] ? read_data[15:0] : read_data[31:16];

    always_comb
    begin
        case (load_size)
            mem_op_pkg::SIZE_BYTE:
            begin
                // Fill with the top bit only for signed loads
                load_result = {{24{sign_ext & sel_byte[7]}}, sel_byte};
            end
            mem_op_pkg::SIZE_HALF:
            begin
                load_result = {{16{sign_ext & sel_half[15]}}, sel_half};
            end
            default:
            begin
                // Word loads pass straight through
                load_result = read_data;
            end
        endcase
    end

endmodule

// File: hdl/mem_op_pkg.sv
// Processor-side access types for the data memory: op codes, size codes, data and address
package mem_op_pkg;

    // Data word and byte address
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;

    // Byte enables, bit 3 is the most significant byte (offset 0, big-endian)
    typedef logic [3:0] byteen_t;

    // Access size field, op bits 1:0
    typedef logic [1:0] size_t;

    localparam size_t SIZE_WORD = 2'b00;
    localparam size_t SIZE_HALF = 2'b01;
    localparam size_t SIZE_BYTE = 2'b11;

    // Field positions inside the op code
    localparam int OP_STORE_BIT = 3;
    localparam int OP_SIGN_BIT  = 2;

    // Operation codes
    // Bit 3 store, bit 2 sign-extend, bits 1:0 size
    typedef enum logic [3:0] {
        OP_LW  = 4'd0,
        OP_LHU = 4'd1,
        OP_LBU = 4'd3,
        OP_LH  = 4'd5,
        OP_LB  = 4'd7,
        OP_SW  = 4'd8,
        OP_SH  = 4'd9,
        OP_SB  = 4'd11
    } mem_op_t;

endpackage

// File: hdl/store_data_translator.sv
// Store data translator, puts store data on big-endian byte lanes with byte enables
module store_data_translator
(
    input  mem_op_pkg::data_t   write_data,
    input  logic [1:0]          byte_offset,
    input  mem_op_pkg::size_t   store_size,
    output mem_op_pkg::byteen_t byteen,
    output mem_op_pkg::data_t   lane_data
);

    always_comb
    begin
        case (store_size)
            mem_op_pkg::SIZE_BYTE:
            begin
                // Lane 3 minus offset, offset 0 is the top byte
                case (byte_offset)
                    2'd0:
                    begin
                        byteen    = 4'b1000;
                        lane_data = {write_data[7:0], 24'b0};
                    end
                    2'd1:
                    begin
                        byteen    = 4'b0100;
                        lane_data = {8'b0, write_data[7:0], 16'b0};
                    end
                    2'd2:
                    begin
                        byteen    = 4'b0010;
                        lane_data = {16'b0, write_data[7:0], 8'b0};
                    end
                    default:
                    begin
                        byteen    = 4'b0001;
                        lane_data = {24'b0, write_data[7:0]};
                    end
                endcase
            end
            mem_op_pkg::SIZE_HALF:
            begin
                // Offset bit 0 ignored for halfwords
                if (!byte_offset[1])
                begin
                    byteen    = 4'b1100;
                    lane_data = {write_data[15:0], 16'b0};
                end
                else
                begin
                    byteen    = 4'b0011;
                    lane_data = {16'b0, write_data[15:0]};
                end
            end
            default:
            begin
                // Word store, all lanes
                byteen    = 4'b1111;
                lane_data = write_data;
            end
        endcase
    end

endmodule

// File: test/data_mem_tb.sv
// Data memory testbench, random accesses checked against a big-endian byte model
module data_mem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DM_AW   = 10;
    localparam int IO_WAIT = 2;

    // Test lengths
    localparam int N_BOOT  = 64;
    localparam int N_STORE = 300;
    localparam int N_LOAD  = 200;
    localparam int N_IO    = 64;
    localparam int N_MIX   = 16;
    localparam int N_BAD   = 32;
    localparam int N_ACCESS = N_BOOT + 2 * N_STORE + N_LOAD + N_IO + 2 * N_MIX + N_BAD + 4;
    localparam int TIMEOUT_CYCLES = (N_ACCESS * (IO_WAIT + 2) + N_BOOT) * 2;

    logic                clk;
    logic                reset;
    logic                en;
    mem_op_pkg::mem_op_t op;
    logic [31:0]         d_address;
    logic [31:0]         d_writedata;
    logic [31:0]         boot_daddr;
    logic [31:0]         boot_ddata;
    logic                boot_dwe;
    logic [31:0]         d_loadresult;
    logic                stalled;
    logic [31:0]         ecause;

    // Bytes 0..255 are RAM words 0..63, bytes 256..271 are the I/O words
    logic [7:0] model [272];

    int errors;
    int n_checks;
    int n_access;
    int cycle_count;

    // Result of the last accepted access, checked in the following cycle
    logic        pend_valid;
    logic        pend_is_load;
    string       pend_name;
    logic [31:0] pend_load;
    logic [31:0] pend_cause;

    mem_op_pkg::mem_op_t store_ops [3] = '{mem_op_pkg::OP_SB, mem_op_pkg::OP_SH,
                                           mem_op_pkg::OP_SW};
    mem_op_pkg::mem_op_t load_ops [4]  = '{mem_op_pkg::OP_LB, mem_op_pkg::OP_LBU,
                                           mem_op_pkg::OP_LH, mem_op_pkg::OP_LHU};
    mem_op_pkg::mem_op_t all_ops [8]   = '{mem_op_pkg::OP_LW, mem_op_pkg::OP_LHU,
                                           mem_op_pkg::OP_LBU, mem_op_pkg::OP_LH,
                                           mem_op_pkg::OP_LB, mem_op_pkg::OP_SW,
                                           mem_op_pkg::OP_SH, mem_op_pkg::OP_SB};

    data_mem_top #(
        .DM_ADDRESSWIDTH (DM_AW),
        .IO_WAIT         (IO_WAIT)
    ) i_data_mem_top (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .op           (op),
        .d_address    (d_address),
        .d_writedata  (d_writedata),
        .boot_daddr   (boot_daddr),
        .boot_ddata   (boot_ddata),
        .boot_dwe     (boot_dwe),
        .d_loadresult (d_loadresult),
        .stalled      (stalled),
        .ecause       (ecause)
    );

    always #4 clk = ~clk;

    // Hard stop on a hung handshake
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run timed out after %0d cycles, a stall never ended", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic is_store(input mem_op_pkg::mem_op_t o);
        return (o == mem_op_pkg::OP_SB) || (o == mem_op_pkg::OP_SH) ||
               (o == mem_op_pkg::OP_SW);
    endfunction

    function automatic int model_idx(input logic [31:0] a);
        return a[31] ? 256 + int'(a[3:0]) : int'(a[7:0]);
    endfunction

    // Big-endian, lowest byte address holds the most significant byte
    function automatic logic [31:0] model_load(input mem_op_pkg::mem_op_t o,
                                               input logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = model[model_idx(a)];
        h = {model[model_idx({a[31:1], 1'b0})], model[model_idx({a[31:1], 1'b1})]};
        w = {model[model_idx({a[31:2], 2'd0})], model[model_idx({a[31:2], 2'd1})],
             model[model_idx({a[31:2], 2'd2})], model[model_idx({a[31:2], 2'd3})]};
        case (o)
            mem_op_pkg::OP_LB:  return {{24{b[7]}}, b};
            mem_op_pkg::OP_LBU: return {24'b0, b};
            mem_op_pkg::OP_LH:  return {{16{h[15]}}, h};
            mem_op_pkg::OP_LHU: return {16'b0, h};
            default:            return w;
        endcase
    endfunction

    task automatic model_store(input mem_op_pkg::mem_op_t o, input logic [31:0] a,
                               input logic [31:0] d);
        case (o)
            mem_op_pkg::OP_SB:
                model[model_idx(a)] = d[7:0];
            mem_op_pkg::OP_SH:
            begin
                model[model_idx({a[31:1], 1'b0})] = d[15:8];
                model[model_idx({a[31:1], 1'b1})] = d[7:0];
            end
            default:
                for (int i = 0; i < 4; i++)
                    model[model_idx({a[31:2], 2'(i)})] = d[31-8*i -: 8];
        endcase
    endtask

    task automatic check_pending();
        if (pend_valid)
        begin
            if (pend_is_load)
                check({pend_name, " load"}, pend_load, d_loadresult);
            check({pend_name, " ecause"}, pend_cause, ecause);
            pend_valid = 1'b0;
        end
    endtask

    // Issue one access at edge plus 1 ns, hold it through the stall, return after acceptance
    task automatic access(input string name, input mem_op_pkg::mem_op_t acc_op,
                          input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] exp_load;
        logic        mapped;
        int          stalls;
        string       tag;
        mapped   = !addr[31] || (addr[30:4] == '0);
        exp_load = 32'd0;
        tag      = $sformatf("%s %s @%h", name, acc_op.name(), addr);
        // Unmapped stores are dropped, unmapped loads return zero
        if (is_store(acc_op) && mapped)
            model_store(acc_op, addr, wdata);
        else if (mapped)
            exp_load = model_load(acc_op, addr);
        en          = 1'b1;
        op          = acc_op;
        d_address   = addr;
        d_writedata = wdata;
        stalls      = 0;
        @(negedge clk);
        // Previous result is valid only in this first cycle
        check_pending();
        while (stalled)
        begin
            stalls++;
            @(negedge clk);
        end
        check({tag, " stall"}, addr[31] ? 32'(IO_WAIT) : 32'd0, 32'(stalls));
        @(posedge clk);
        #1;
        pend_valid   = 1'b1;
        pend_is_load = !is_store(acc_op);
        pend_name    = tag;
        pend_load    = exp_load;
        pend_cause   = mapped ? 32'd0 : 32'd7;
        n_access++;
    endtask

    // Drop en and check the last outstanding result
    task automatic flush();
        en = 1'b0;
        @(negedge clk);
        check_pending();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] ram_addr();
        return {24'b0, 6'($urandom % 64), 2'($urandom % 4)};
    endfunction

    function automatic logic [31:0] io_addr(input int word);
        return 32'h8000_0000 | (32'(word) << 2) | 32'($urandom % 4);
    endfunction

    initial
    begin
        logic [31:0] a;
        void'($urandom(79237));
        clk = 1'b0;
        reset = 1'b1;
        en = 1'b0;
        op = mem_op_pkg::OP_LW;
        d_address = '0;
        d_writedata = '0;
        boot_daddr = '0;
        boot_ddata = '0;
        boot_dwe = 1'b0;
        errors = 0;
        n_checks = 0;
        n_access = 0;
        cycle_count = 0;
        pend_valid = 1'b0;
        // I/O registers come out of reset cleared
        for (int i = 256; i < 272; i++)
            model[i] = 8'h00;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle outputs after reset
        @(negedge clk);
        check("idle stalled", 32'd0, 32'(stalled));
        check("idle ecause", 32'd0, ecause);
        @(posedge clk);
        #1;

        // Boot port fills RAM words 0..63
        for (int i = 0; i < N_BOOT; i++)
        begin
            boot_dwe   = 1'b1;
            boot_daddr = 32'(i) << 2;
            boot_ddata = $urandom;
            model_store(mem_op_pkg::OP_SW, boot_daddr, boot_ddata);
            @(posedge clk);
            #1;
        end
        boot_dwe = 1'b0;
        for (int i = 0; i < N_BOOT; i++)
            access("boot_readback", mem_op_pkg::OP_LW, 32'(i) << 2, $urandom);

        // Each store is read back as a whole word
        for (int i = 0; i < N_STORE; i++)
        begin
            a = ram_addr();
            access("store_readback", store_ops[$urandom % 3], a, $urandom);
            access("store_readback", mem_op_pkg::OP_LW, a, $urandom);
        end

        for (int i = 0; i < N_LOAD; i++)
            access("load_ext", load_ops[$urandom % 4], ram_addr(), $urandom);

        for (int i = 0; i < N_IO; i++)
            access("io_access", all_ops[$urandom % 8], io_addr($urandom % 4), $urandom);

        // RAM load right behind an I/O load
        for (int i = 0; i < N_MIX; i++)
        begin
            access("io_then_ram", mem_op_pkg::OP_LW, io_addr($urandom % 4), $urandom);
            access("io_then_ram", mem_op_pkg::OP_LW, ram_addr(), $urandom);
        end

        for (int i = 0; i < N_BAD; i++)
            access("unmapped", all_ops[$urandom % 8], io_addr(4 + $urandom % 252), $urandom);
        // Dropped stores must leave the mapped words alone
        for (int i = 0; i < 4; i++)
            access("io_after_unmapped", mem_op_pkg::OP_LW, io_addr(i), $urandom);
        flush();

        $display("Done: %0d accesses, %0d checks, %0d errors", n_access, n_checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
